// File: filelist.f
verilog/div_pkg.sv
verilog/div_step.sv
verilog/div_rank.sv
verilog/div_top.sv
verification/div_tb_props.sv
verification/div_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=div_tb_sim
LOG=sim.log

echo "compiling with verilator"
verilator --binary --assert \
	-f filelist.f \
	--top-module div_tb \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

echo "running simulation"
"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if ! grep -q "TEST PASS" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"
exit 0

// File: verification/div_tb.sv
`timescale 1ns/1ps

module div_tb;

	// one expected result and the cycle its strobe was driven
	typedef struct packed {
		div_pkg::dividend_t q;
		div_pkg::divisor_t  r;
		logic [31:0]        cyc;
	} exp_t;

	logic               clk;
	logic               i_arst_n;
	logic               i_in_valid;
	div_pkg::dividend_t i_a;
	div_pkg::divisor_t  i_b;
	div_pkg::dividend_t o_q;
	div_pkg::divisor_t  o_r;
	logic               o_out_valid;

	integer      seed;
	logic [31:0] cycle_cnt = '0;
	string       test_name;
	exp_t        exp_q [$];
	exp_t        head;

	div_top uut (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_in_valid  (i_in_valid),
		.i_a         (i_a),
		.i_b         (i_b),
		.o_q         (o_q),
		.o_r         (o_r),
		.o_out_valid (o_out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// restoring division reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic void ref_divide(input div_pkg::dividend_t a, input div_pkg::divisor_t b,
		output div_pkg::dividend_t q, output div_pkg::divisor_t r);
		div_pkg::prem_t prem;
		div_pkg::prem_t shifted;
		prem = '0;
		q = '0;
		for (int i = div_pkg::DIVIDEND_W - 1; i >= 0; i--) begin
			// shift left with the next bit in at the bottom
			shifted = div_pkg::prem_t'({prem, a[i]});
			if (shifted >= div_pkg::prem_t'(b)) begin
				prem = shifted - div_pkg::prem_t'(b);
				q[i] = 1'b1;
			end else begin
				prem = shifted;
				q[i] = 1'b0;
			end
		end
		r = prem[div_pkg::DIVISOR_W-1:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected %0d actual %0d", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic drive_op(input div_pkg::dividend_t a, input div_pkg::divisor_t b);
		exp_t e;
		@(negedge clk);
		i_in_valid = 1'b1;
		i_a = a;
		i_b = b;
		ref_divide(a, b, e.q, e.r);
		e.cyc = cycle_cnt;
		exp_q.push_back(e);
	endtask

	// junk operands while idle
	task automatic idle_cycle;
		@(negedge clk);
		i_in_valid = 1'b0;
		i_a = 8'($random(seed));
		i_b = 5'($random(seed));
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		idle_cycle();
		while (exp_q.size() != 0) begin
			if (n >= limit) begin
				abort_run({"timed out in ", test_name,
					" waiting for results to come out"});
			end else begin
				@(negedge clk);
				n++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// scoreboard
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (i_arst_n && o_out_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("o_out_valid went high with no operation in flight");
			end else begin
				head = exp_q.pop_front();
				check({test_name, " latency"}, 32'(div_pkg::NUM_RANKS),
					cycle_cnt - head.cyc);
				check({test_name, " quotient"}, 32'(head.q), 32'(o_q));
				check({test_name, " remainder"}, 32'(head.r), 32'(o_r));
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : main_seq
		integer rnd;
		seed = 32'h9463;
		i_arst_n = 1'b0;
		i_in_valid = 1'b0;
		i_a = '0;
		i_b = '0;
		test_name = "reset";

		repeat (10) begin
			@(negedge clk);
			check("reset valid", 32'(0), 32'(o_out_valid));
		end
		i_arst_n = 1'b1;

		test_name = "idle_after_reset";
		repeat (10) begin
			@(negedge clk);
			check("idle valid", 32'(0), 32'(o_out_valid));
		end

		test_name = "single";
		drive_op(8'd200, 5'd7);
		wait_drain(20);

		// one per cycle to fill all seven ranks
		test_name = "back_to_back";
		repeat (200) begin
			drive_op(8'($random(seed)), 5'($random(seed)));
		end
		wait_drain(20);

		test_name = "corner";
		drive_op(8'd100, 5'd1);
		drive_op(8'd255, 5'd1);
		drive_op(8'd200, 5'd31);
		drive_op(8'd0, 5'd13);
		drive_op(8'd9, 5'd20);
		drive_op(8'd30, 5'd31);
		drive_op(8'd255, 5'd31);
		wait_drain(20);

		// expect an all ones quotient and the low dividend bits as remainder
		test_name = "zero_divisor";
		drive_op(8'd0, 5'd0);
		drive_op(8'd255, 5'd0);
		drive_op(8'd77, 5'd0);
		drive_op(8'd160, 5'd0);
		wait_drain(20);

		test_name = "random_gaps";
		repeat (300) begin
			rnd = $random(seed);
			if (rnd[0]) begin
				drive_op(8'($random(seed)), 5'($random(seed)));
			end else begin
				idle_cycle();
			end
		end
		wait_drain(20);

		// nothing in flight now so any further strobe is a stray result
		test_name = "quiet_end";
		repeat (2 * div_pkg::NUM_RANKS) begin
			idle_cycle();
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

// File: verification/div_tb_props.sv
`timescale 1ns/1ps

// latency, reset and remainder range of the divider
module div_tb_props (
	input logic              clk,
	input logic              i_arst_n,
	input logic              i_in_valid,
	input div_pkg::divisor_t i_b,
	input div_pkg::divisor_t o_r,
	input logic              o_out_valid
);

	// result strobe is the input strobe seven cycles on
	a_latency: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_out_valid == $past(i_in_valid, div_pkg::NUM_RANKS))
		else $error("o_out_valid does not follow i_in_valid by the pipeline latency");

	a_reset_low: assert property (@(posedge clk)
		!i_arst_n |-> !o_out_valid)
		else $error("o_out_valid high during reset");

	// remainder below its own divisor, zero divisor left out
	a_rem_range: assert property (@(posedge clk) disable iff (!i_arst_n)
		(o_out_valid && $past(i_b, div_pkg::NUM_RANKS) != '0)
		|-> o_r < $past(i_b, div_pkg::NUM_RANKS))
		else $error("remainder not below the divisor");

endmodule

bind div_top div_tb_props u_props (
	.clk         (clk),
	.i_arst_n    (i_arst_n),
	.i_in_valid  (i_in_valid),
	.i_b         (i_b),
	.o_r         (o_r),
	.o_out_valid (o_out_valid)
);

// File: verilog/div_pkg.sv
package div_pkg;

	////////////////////////////////////////////////////////////////////////////
	// operand and result widths
	////////////////////////////////////////////////////////////////////////////

	// dividend and quotient
	localparam int DIVIDEND_W = 8;

	// divisor and remainder
	localparam int DIVISOR_W = 5;

	// one extra bit so the shifted remainder can exceed the divisor
	localparam int PREM_W = DIVISOR_W + 1;

	////////////////////////////////////////////////////////////////////////////
	// pipeline shape
	////////////////////////////////////////////////////////////////////////////

	// register ranks and also the latency in cycles
	localparam int NUM_RANKS = 7;

	// steps folded into the first rank
	localparam int FIRST_RANK_STEPS = 2;

	// steps in each later rank
	localparam int STEPS_PER_RANK = 1;

	// 2 + 6 * 1 = 8 steps for the 8 dividend bits

	////////////////////////////////////////////////////////////////////////////
	// data types
	////////////////////////////////////////////////////////////////////////////

	// dividend, remaining dividend bits, quotient
	typedef logic [DIVIDEND_W-1:0] dividend_t;

	// divisor, remainder
	typedef logic [DIVISOR_W-1:0] divisor_t;

	// partial remainder between steps
	typedef logic [PREM_W-1:0] prem_t;

endpackage

// File: verilog/div_rank.sv
`timescale 1ns/1ps

// one pipeline rank: NUM_STEPS restoring steps in a row, then one set of
// registers for the operation moving on to the next rank
module div_rank #(
	parameter int NUM_STEPS = 1
) (
	input  logic               clk,
	input  logic               i_arst_n,

	// from the previous rank
	input  logic               i_valid,
	input  div_pkg::dividend_t i_rest,
	input  div_pkg::dividend_t i_quot,
	input  div_pkg::prem_t     i_prem,
	input  div_pkg::divisor_t  i_divisor,

	// to the next rank
	output logic               o_valid,
	output div_pkg::dividend_t o_rest,
	output div_pkg::dividend_t o_quot,
	output div_pkg::prem_t     o_prem,
	output div_pkg::divisor_t  o_divisor
);

	// combinational values between the steps
	// index 0 is the rank input, index NUM_STEPS feeds the registers
	div_pkg::dividend_t rest_c [0:NUM_STEPS];
	div_pkg::dividend_t quot_c [0:NUM_STEPS];
	div_pkg::prem_t     prem_c [0:NUM_STEPS];

	// quotient bit out of each step
	logic qbit [0:NUM_STEPS-1];

	// rank registers
	logic               valid_q;
	div_pkg::dividend_t rest_q;
	div_pkg::dividend_t quot_q;
	div_pkg::prem_t     prem_q;
	div_pkg::divisor_t  divisor_q;

	////////////////////////////////////////////////////////////////////////////
	// step chain
	////////////////////////////////////////////////////////////////////////////

	assign rest_c[0] = i_rest;
	assign quot_c[0] = i_quot;
	assign prem_c[0] = i_prem;

	genvar s;
	generate
		for (s = 0; s < NUM_STEPS; s++) begin : g_step

			// next dividend bit is the msb of what is left
			div_step u_step (
				.i_prem    (prem_c[s]),
				.i_bit     (rest_c[s][div_pkg::DIVIDEND_W-1]),
				.i_divisor (i_divisor),
				.o_prem    (prem_c[s+1]),
				.o_qbit    (qbit[s])
			);

			// consume the bit just used
			assign rest_c[s+1] = {rest_c[s][div_pkg::DIVIDEND_W-2:0], 1'b0};

			// new quotient bit enters at the bottom
			assign quot_c[s+1] = {quot_c[s][div_pkg::DIVIDEND_W-2:0], qbit[s]};

		end
	endgenerate

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	// valid moves every cycle so bubbles travel as well
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_valid;
		end
	end

	// data only on a valid operation, holds through idle cycles
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rest_q    <= '0;
			quot_q    <= '0;
			prem_q    <= '0;
			divisor_q <= '0;
		end else if (i_valid) begin
			rest_q    <= rest_c[NUM_STEPS];
			quot_q    <= quot_c[NUM_STEPS];
			prem_q    <= prem_c[NUM_STEPS];
			// divisor travels with its operand
			divisor_q <= i_divisor;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////////////

	assign o_valid   = valid_q;
	assign o_rest    = rest_q;
	assign o_quot    = quot_q;
	assign o_prem    = prem_q;
	assign o_divisor = divisor_q;

endmodule

// File: verilog/div_step.sv
`timescale 1ns/1ps

// one restoring step: shift in a dividend bit, try the subtraction,
// keep the difference when it does not borrow
module div_step (
	input  div_pkg::prem_t    i_prem,
	input  logic              i_bit,
	input  div_pkg::divisor_t i_divisor,
	output div_pkg::prem_t    o_prem,
	output logic              o_qbit
);

	// shifted partial remainder, next dividend bit at the bottom
	div_pkg::prem_t shifted;

	// divisor zero-extended to the remainder width
	div_pkg::prem_t divisor_ext;

	// difference with one extra bit on top for the borrow
	logic [div_pkg::PREM_W:0] diff_ext;

	// borrow out of the trial subtraction
	logic borrow;

	////////////////////////////////////////////////////////////////////////////
	// shift
	////////////////////////////////////////////////////////////////////////////

	// top bit of i_prem drops out, it is always zero while
	// the remainder stays below a nonzero divisor
	assign shifted = {i_prem[div_pkg::PREM_W-2:0], i_bit};

	assign divisor_ext = {1'b0, i_divisor};

	////////////////////////////////////////////////////////////////////////////
	// trial subtraction
	////////////////////////////////////////////////////////////////////////////

	assign diff_ext = {1'b0, shifted} - {1'b0, divisor_ext};

	// borrow set means shifted < divisor
	assign borrow = diff_ext[div_pkg::PREM_W];

	////////////////////////////////////////////////////////////////////////////
	// restore or keep
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		if (borrow) begin
			// restore, the subtraction is thrown away
			o_prem = shifted;
		end else begin
			o_prem = diff_ext[div_pkg::PREM_W-1:0];
		end
	end

	// quotient bit is 1 when the divisor fit
	// a zero divisor always fits, so every bit comes out 1
	assign o_qbit = ~borrow;

endmodule

// File: verilog/div_top.sv
`timescale 1ns/1ps

// 8 by 5 bit unsigned restoring divider
// seven ranks, one new operation per cycle, result seven cycles later
module div_top (
	input  logic               clk,
	input  logic               i_arst_n,

	// operation in
	input  logic               i_in_valid,
	input  div_pkg::dividend_t i_a,
	input  div_pkg::divisor_t  i_b,

	// result out
	output div_pkg::dividend_t o_q,
	output div_pkg::divisor_t  o_r,
	output logic               o_out_valid
);

	// rank chain, entry r feeds rank r, entry r+1 is its output
	logic               valid_c   [0:div_pkg::NUM_RANKS];
	div_pkg::dividend_t rest_c    [0:div_pkg::NUM_RANKS];
	div_pkg::dividend_t quot_c    [0:div_pkg::NUM_RANKS];
	div_pkg::prem_t     prem_c    [0:div_pkg::NUM_RANKS];
	div_pkg::divisor_t  divisor_c [0:div_pkg::NUM_RANKS];

	////////////////////////////////////////////////////////////////////////////
	// chain entry
	////////////////////////////////////////////////////////////////////////////

	// rank 0 works straight on the input ports
	assign valid_c[0]   = i_in_valid;
	assign rest_c[0]    = i_a;
	assign divisor_c[0] = i_b;

	// nothing computed yet
	assign quot_c[0] = '0;
	assign prem_c[0] = '0;

	////////////////////////////////////////////////////////////////////////////
	// ranks
	////////////////////////////////////////////////////////////////////////////

	genvar r;
	generate
		for (r = 0; r < div_pkg::NUM_RANKS; r++) begin : g_rank

			// first rank carries two steps, the rest one each
			localparam int RANK_STEPS = (r == 0) ?
				div_pkg::FIRST_RANK_STEPS : div_pkg::STEPS_PER_RANK;

			div_rank #(
				.NUM_STEPS (RANK_STEPS)
			) u_rank (
				.clk       (clk),
				.i_arst_n  (i_arst_n),
				.i_valid   (valid_c[r]),
				.i_rest    (rest_c[r]),
				.i_quot    (quot_c[r]),
				.i_prem    (prem_c[r]),
				.i_divisor (divisor_c[r]),
				.o_valid   (valid_c[r+1]),
				.o_rest    (rest_c[r+1]),
				.o_quot    (quot_c[r+1]),
				.o_prem    (prem_c[r+1]),
				.o_divisor (divisor_c[r+1])
			);

		end
	endgenerate

	////////////////////////////////////////////////////////////////////////////
	// result
	////////////////////////////////////////////////////////////////////////////

	// all dividend bits are used up by the last rank
	assign o_q = quot_c[div_pkg::NUM_RANKS];

	// remainder fits in DIVISOR_W bits for any nonzero divisor
	// for a zero divisor this gives the low dividend bits
	assign o_r = prem_c[div_pkg::NUM_RANKS][div_pkg::DIVISOR_W-1:0];

	// follows the input strobe, not the divisor value
	assign o_out_valid = valid_c[div_pkg::NUM_RANKS];

endmodule
